//--- hw/brownout_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared constants, enums and the event record of the brownout monitor
// Every design file refers to these by package-scoped names
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package brownout_pkg;

  // Sample and hysteresis widths
  localparam int LEVEL_W = 8;
  localparam int HYST_W  = 4;

  // Wrapping event number width
  localparam int SEQ_W = 4;

  // Event FIFO geometry, depth is a power of two
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = 2;

  // Request hold after a recovery event is popped
  localparam int HOLD_CYCLES = 8;
  localparam int HOLD_CNT_W  = $clog2(HOLD_CYCLES);
  localparam logic [HOLD_CNT_W-1:0] HOLD_LOAD = HOLD_CNT_W'(HOLD_CYCLES - 1);

  // Detector state
  typedef enum logic {
    MON_NORMAL,
    MON_BROWNOUT
  } mon_state_e;

  // Event opcode
  typedef enum logic {
    EV_BROWNOUT,   // level fell below the base threshold
    EV_RECOVER     // level rose above the raised threshold
  } ev_kind_e;

  // Sequencer state
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ACTIVE,
    SEQ_HOLD
  } seq_state_e;

  // One queued event, 13 bits
  typedef struct packed {
    ev_kind_e           kind;
    logic [LEVEL_W-1:0] level;
    logic [SEQ_W-1:0]   seq;
  } brownout_event_t;

endpackage

`default_nettype wire

//--- hw/brownout_event_if.sv
////////////////////////////////////////////////////////////////////////////
// Crossing events from the threshold detector into the event FIFO
// Single-cycle strobe, no back-pressure; every strobe is a push
////////////////////////////////////////////////////////////////////////////
`default_nettype none

interface brownout_event_if;

  // High for one cycle per event
  logic ev_strobe;

  // Event payload, valid while ev_strobe is high
  brownout_pkg::ev_kind_e             ev_kind;
  logic [brownout_pkg::LEVEL_W-1:0]   ev_level;
  logic [brownout_pkg::SEQ_W-1:0]     ev_seq;

  // Detector side
  modport source (
    output ev_strobe,
    output ev_kind,
    output ev_level,
    output ev_seq
  );

  // FIFO side
  modport sink (
    input ev_strobe,
    input ev_kind,
    input ev_level,
    input ev_seq
  );

endinterface

`default_nettype wire

//--- hw/threshold_detector.sv
////////////////////////////////////////////////////////////////////////////
// Adaptive-threshold comparator with hysteresis
// Tracks normal/brownout state per sample and emits an event per change
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module threshold_detector (
  input  logic                               clk,
  input  logic                               reset_trigger,
  input  logic                               sample_strobe,
  input  logic [brownout_pkg::LEVEL_W-1:0]   signal_level,
  input  logic [brownout_pkg::LEVEL_W-1:0]   base_threshold,
  input  logic [brownout_pkg::HYST_W-1:0]    hysteresis,
  output logic [brownout_pkg::LEVEL_W-1:0]   threshold,
  brownout_event_if.source                   ev
);

  brownout_pkg::mon_state_e              state;
  brownout_pkg::mon_state_e              state_next;
  logic [brownout_pkg::LEVEL_W:0]        raised_sum;
  logic [brownout_pkg::LEVEL_W-1:0]      raised_thr;
  logic                                  falling;
  logic                                  rising;

  // Base plus hysteresis, one extra bit for the carry
  assign raised_sum = {1'b0, base_threshold} +
                      {{(brownout_pkg::LEVEL_W + 1 - brownout_pkg::HYST_W){1'b0}},
                       hysteresis};

  // Saturate at full scale
  assign raised_thr = raised_sum[brownout_pkg::LEVEL_W] ? '1 :
                      raised_sum[brownout_pkg::LEVEL_W-1:0];

  // Crossing tests against the threshold of the current state
  assign falling = (state == brownout_pkg::MON_NORMAL) &&
                   (signal_level < base_threshold);
  assign rising  = (state == brownout_pkg::MON_BROWNOUT) &&
                   (signal_level > raised_thr);

  always_comb begin
    state_next = state;
    if (falling) begin
      state_next = brownout_pkg::MON_BROWNOUT;
    end else if (rising) begin
      state_next = brownout_pkg::MON_NORMAL;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // State, threshold and event control
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_trigger) begin
      state        <= brownout_pkg::MON_NORMAL;
      threshold    <= '0;
      ev.ev_strobe <= 1'b0;
      ev.ev_seq    <= '0;
    end else begin
      // Strobe lasts one cycle
      ev.ev_strobe <= 1'b0;
      if (sample_strobe) begin
        state <= state_next;
        // Active threshold of the state just entered
        threshold <= (state_next == brownout_pkg::MON_BROWNOUT) ? raised_thr
                                                                : base_threshold;
        if (falling || rising) begin
          ev.ev_strobe <= 1'b1;
          // Counter doubles as the event number, wraps at 16
          ev.ev_seq    <= ev.ev_seq + 1'b1;
        end
      end
    end
  end

  // Event payload, only meaningful alongside the strobe
  always_ff @(posedge clk) begin
    if (sample_strobe && (falling || rising)) begin
      ev.ev_kind  <= falling ? brownout_pkg::EV_BROWNOUT : brownout_pkg::EV_RECOVER;
      ev.ev_level <= signal_level;
    end
  end

endmodule

`default_nettype wire

//--- hw/event_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Small circular FIFO for crossing events, with a sticky overflow flag
// Pushes come from the event interface; the sequencer pops from head
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module event_fifo (
  input  logic                           clk,
  input  logic                           reset_trigger,
  brownout_event_if.sink                 ev,
  input  logic                           pop,
  output logic                           empty,
  output brownout_pkg::brownout_event_t  head,
  output logic                           overflow
);

  // Storage, no reset needed
  brownout_pkg::brownout_event_t         mem [brownout_pkg::FIFO_DEPTH];

  logic [brownout_pkg::FIFO_PTR_W-1:0]   wr_ptr;
  logic [brownout_pkg::FIFO_PTR_W-1:0]   rd_ptr;
  logic [brownout_pkg::FIFO_PTR_W:0]     count;
  logic                                  full;
  logic                                  do_push;
  logic                                  do_pop;

  // Count never exceeds depth, so its top bit means full
  assign full    = count[brownout_pkg::FIFO_PTR_W];
  assign empty   = (count == '0);
  assign do_push = ev.ev_strobe && !full;
  // Pop while empty is ignored
  assign do_pop  = pop && !empty;

  // Oldest entry always visible
  assign head = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= '{kind: ev.ev_kind, level: ev.ev_level, seq: ev.ev_seq};
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Pointers, occupancy and overflow
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_trigger) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // Pointers wrap naturally at the power-of-two depth
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Dropped push, sticky until reset
      if (ev.ev_strobe && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/reset_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Turns queued brownout/recovery events into the outgoing reset request
// Recovery keeps the request up for a fixed hold before release
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module reset_sequencer (
  input  logic                            clk,
  input  logic                            reset_trigger,
  input  logic                            empty,
  input  brownout_pkg::brownout_event_t   head,
  output logic                            pop,
  output logic                            reset_req,
  output logic [brownout_pkg::SEQ_W-1:0]  last_event_seq
);

  brownout_pkg::seq_state_e               state;
  logic [brownout_pkg::HOLD_CNT_W-1:0]    hold_cnt;

  // Drain whenever something is queued, except while holding
  assign pop = !empty && (state != brownout_pkg::SEQ_HOLD);

  //////////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_trigger) begin
      state          <= brownout_pkg::SEQ_IDLE;
      hold_cnt       <= '0;
      reset_req      <= 1'b0;
      last_event_seq <= '0;
    end else begin
      case (state)
        brownout_pkg::SEQ_IDLE,
        brownout_pkg::SEQ_ACTIVE: begin
          if (pop) begin
            last_event_seq <= head.seq;
            if (head.kind == brownout_pkg::EV_BROWNOUT) begin
              // Raise request on the next edge
              state     <= brownout_pkg::SEQ_ACTIVE;
              reset_req <= 1'b1;
            end else begin
              // Request level untouched here, released after the hold
              state    <= brownout_pkg::SEQ_HOLD;
              hold_cnt <= brownout_pkg::HOLD_LOAD;
            end
          end
        end

        brownout_pkg::SEQ_HOLD: begin
          // HOLD_CYCLES cycles in this state, then release
          if (hold_cnt == '0) begin
            state     <= brownout_pkg::SEQ_IDLE;
            reset_req <= 1'b0;
          end else begin
            hold_cnt <= hold_cnt - 1'b1;
          end
        end

        default: begin
          state     <= brownout_pkg::SEQ_IDLE;
          reset_req <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/brownout_monitor_top.sv
////////////////////////////////////////////////////////////////////////////
// Brownout monitor top: detector, event FIFO and reset sequencer
// Plain ports only; the detector-to-FIFO link runs over the event interface
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module brownout_monitor_top (
  input  logic                              clk,
  input  logic                              reset_trigger,
  input  logic                              sample_strobe,
  input  logic [brownout_pkg::LEVEL_W-1:0]  signal_level,
  input  logic [brownout_pkg::LEVEL_W-1:0]  base_threshold,
  input  logic [brownout_pkg::HYST_W-1:0]   hysteresis,
  output logic [brownout_pkg::LEVEL_W-1:0]  threshold,
  output logic                              reset_req,
  output logic                              overflow,
  output logic [brownout_pkg::SEQ_W-1:0]    last_event_seq
);

  // FIFO to sequencer link
  logic                           pop;
  logic                           empty;
  brownout_pkg::brownout_event_t  head;

  // Detector to FIFO events
  brownout_event_if ev_if ();

  threshold_detector i_threshold_detector (
    .clk            (clk),
    .reset_trigger  (reset_trigger),
    .sample_strobe  (sample_strobe),
    .signal_level   (signal_level),
    .base_threshold (base_threshold),
    .hysteresis     (hysteresis),
    .threshold      (threshold),
    .ev             (ev_if.source)
  );

  event_fifo i_event_fifo (
    .clk           (clk),
    .reset_trigger (reset_trigger),
    .ev            (ev_if.sink),
    .pop           (pop),
    .empty         (empty),
    .head          (head),
    .overflow      (overflow)
  );

  reset_sequencer i_reset_sequencer (
    .clk            (clk),
    .reset_trigger  (reset_trigger),
    .empty          (empty),
    .head           (head),
    .pop            (pop),
    .reset_req      (reset_req),
    .last_event_seq (last_event_seq)
  );

endmodule

`default_nettype wire

//--- tb/brownout_monitor_checker.sv
////////////////////////////////////////////////////////////////////////////
// Reference model and comparator for the brownout monitor ports
// Tracks the hysteresis state per sample; compares at testbench checkpoints
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module brownout_monitor_checker (
  input logic       clk,
  input logic       reset_trigger,
  input logic       sample_strobe,
  input logic [7:0] signal_level,
  input logic [7:0] base_threshold,
  input logic [3:0] hysteresis,
  input logic [7:0] threshold,
  input logic       reset_req,
  input logic       overflow,
  input logic [3:0] last_event_seq,
  input logic [1:0] checkpoint
);
  timeunit 1ns;
  timeprecision 1ps;

  int         err_count = 0;
  int         cyc = 0;
  int         rec_cyc = 0;
  int         ref_events, ref_bo_count, ref_rec_count;
  int         dut_rises, dut_falls;
  logic       ref_bo, nxt_bo, prev_req, thr_pending, rst_seen;
  logic [7:0] exp_thr;

  // Base in normal state, base plus hysteresis capped at 255 in brownout
  function automatic logic [7:0] active_threshold(input logic in_bo,
      input logic [7:0] base, input logic [3:0] hyst);
    int raised;
    raised = int'(base) + int'(hyst);
    if (!in_bo) return base;
    return (raised > 255) ? 8'd255 : 8'(raised);
  endfunction

  // Fall below base enters brownout, rise above raised level leaves it
  function automatic logic next_brownout(input logic in_bo, input logic [7:0] level,
      input logic [7:0] base, input logic [3:0] hyst);
    if (!in_bo) return level < base;
    return !(level > active_threshold(1'b1, base, hyst));
  endfunction

  task automatic report(input string msg);
    err_count++;
    $display("ERR @%0t: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    cyc++;
    if (reset_trigger) begin
      {ref_bo, prev_req, thr_pending, rst_seen} = 4'b0001;
      {ref_events, ref_bo_count, ref_rec_count, dut_rises, dut_falls} = '0;
    end else begin
      // First cycle out of reset, everything cleared
      if (rst_seen && (threshold != 0 || reset_req || overflow || last_event_seq != 0))
        report("outputs not cleared by reset");
      rst_seen = 1'b0;
      if (thr_pending && threshold !== exp_thr)
        report($sformatf("threshold %0d, expected %0d", threshold, exp_thr));
      thr_pending = 1'b0;
      if (reset_req && !prev_req) dut_rises++;
      if (!reset_req && prev_req) begin
        dut_falls++;
        // Hold timing only meaningful without dropped events
        if (!overflow && cyc - 1 - rec_cyc < brownout_pkg::HOLD_CYCLES)
          report($sformatf("reset_req released %0d cycles after recovery",
                           cyc - 1 - rec_cyc));
      end
      prev_req = reset_req;
      if (sample_strobe) begin
        nxt_bo = next_brownout(ref_bo, signal_level, base_threshold, hysteresis);
        if (nxt_bo != ref_bo) begin
          ref_events++;
          if (nxt_bo) ref_bo_count++;
          else begin
            ref_rec_count++;
            rec_cyc = cyc;
          end
        end
        ref_bo      = nxt_bo;
        exp_thr     = active_threshold(ref_bo, base_threshold, hysteresis);
        thr_pending = 1'b1;
      end
      // Settled: edge counts, event number, no overflow yet
      if (checkpoint == 2'd1) begin
        if (dut_rises != ref_bo_count || dut_falls != ref_rec_count)
          report($sformatf("reset_req edges %0d/%0d, expected %0d/%0d",
                           dut_rises, dut_falls, ref_bo_count, ref_rec_count));
        if (last_event_seq != 4'(ref_events))
          report($sformatf("last_event_seq %0d, expected %0d",
                           last_event_seq, 4'(ref_events)));
        if (overflow) report("overflow set before the burst");
      end
      if (checkpoint == 2'd2 && !overflow) report("overflow not set by the burst");
    end
  end

endmodule

`default_nettype wire

//--- tb/brownout_monitor_chk.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions bound into the reset sequencer and the event FIFO
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module brownout_monitor_chk (
  input logic clk,
  input logic reset_trigger,
  input logic pop,
  input logic empty,
  input logic in_hold,
  input logic reset_req,
  input logic overflow
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // Never pop an empty FIFO
  pop_has_data: assert property (@(posedge clk) disable iff (reset_trigger)
    !(pop && empty))
    else begin
      $error("pop asserted while FIFO empty");
      fail_count++;
    end

  // Release only after a full hold in SEQ_HOLD
  hold_before_release: assert property (@(posedge clk) disable iff (reset_trigger)
    $fell(reset_req) |-> $past(in_hold, brownout_pkg::HOLD_CYCLES))
    else begin
      $error("reset_req fell before the hold completed");
      fail_count++;
    end

  // Sticky until reset
  overflow_sticky: assert property (@(posedge clk) disable iff (reset_trigger)
    !$fell(overflow))
    else begin
      $error("overflow cleared outside reset");
      fail_count++;
    end

endmodule

bind reset_sequencer brownout_monitor_chk i_seq_chk (
  .clk           (clk),
  .reset_trigger (reset_trigger),
  .pop           (pop),
  .empty         (empty),
  .in_hold       (state == brownout_pkg::SEQ_HOLD),
  .reset_req     (reset_req),
  .overflow      (1'b0)
);

bind event_fifo brownout_monitor_chk i_fifo_chk (
  .clk           (clk),
  .reset_trigger (reset_trigger),
  .pop           (pop),
  .empty         (empty),
  .in_hold       (1'b0),
  .reset_req     (1'b0),
  .overflow      (overflow)
);

`default_nettype wire

//--- tb/brownout_monitor_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench top for the brownout monitor: clock, reset, seeded stimulus
// The checker instance compares; this module prints the final verdict
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module brownout_monitor_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // Wide spacing lets every event drain before the next sample
  localparam int SPACING = brownout_pkg::HOLD_CYCLES + 4;
  // Samples over all phases
  localparam int SAMPLE_COUNT = 71;
  localparam int CYCLE_LIMIT = SAMPLE_COUNT * SPACING +
    brownout_pkg::FIFO_DEPTH * (brownout_pkg::HOLD_CYCLES + 2) + 200;

  logic       clk;
  logic       reset_trigger;
  logic       sample_strobe;
  logic [7:0] signal_level;
  logic [7:0] base_threshold;
  logic [3:0] hysteresis;
  logic [7:0] threshold;
  logic       reset_req;
  logic       overflow;
  logic [3:0] last_event_seq;
  logic [1:0] checkpoint;
  int         cycles = 0;
  int         assert_fails;

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  brownout_monitor_top i_brownout_monitor_top (
    .clk            (clk),
    .reset_trigger  (reset_trigger),
    .sample_strobe  (sample_strobe),
    .signal_level   (signal_level),
    .base_threshold (base_threshold),
    .hysteresis     (hysteresis),
    .threshold      (threshold),
    .reset_req      (reset_req),
    .overflow       (overflow),
    .last_event_seq (last_event_seq)
  );

  brownout_monitor_checker i_checker (.*);

  // One strobed sample, then idle for the rest of the slot
  task automatic send_sample(input logic [7:0] level, input int gap);
    sample_strobe = 1'b1;
    signal_level  = level;
    @(negedge clk);
    sample_strobe = 1'b0;
    repeat (gap - 1) @(negedge clk);
  endtask

  // Let FIFO and hold drain, then request a comparison of the given kind
  task automatic settle(input logic [1:0] kind);
    repeat (SPACING) @(negedge clk);
    checkpoint = kind;
    @(negedge clk);
    checkpoint = 2'd0;
  endtask

  task automatic pulse_reset();
    reset_trigger = 1'b1;
    repeat (2) @(negedge clk);
    reset_trigger = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Stimulus, driven on the falling edge
  //////////////////////////////////////////////////////////////////////////
  initial begin
    int i;
    reset_trigger  = 1'b1;
    sample_strobe  = 1'b0;
    signal_level   = '0;
    base_threshold = '0;
    hysteresis     = '0;
    checkpoint     = 2'd0;
    void'($urandom(32'hb5f8_00f9));
    repeat (2) @(negedge clk);
    reset_trigger = 1'b0;

    // Random levels around a random base
    base_threshold = 8'($urandom_range(40, 200));
    hysteresis     = 4'($urandom_range(1, 15));
    for (i = 0; i < 24; i++) begin
      send_sample(8'($urandom_range(0, 255)), SPACING);
    end
    // Raised threshold saturates at full scale
    base_threshold = 8'd250;
    hysteresis     = 4'd12;
    send_sample(8'd0, SPACING);
    for (i = 0; i < 3; i++) begin
      send_sample(8'($urandom_range(0, 255)), SPACING);
    end

    // Dither inside the hysteresis band, normal then brownout
    base_threshold = 8'd120;
    hysteresis     = 4'd10;
    send_sample(8'd255, SPACING);
    for (i = 0; i < 10; i++) begin
      send_sample(8'($urandom_range(120, 130)), SPACING);
    end
    send_sample(8'd0, SPACING);
    for (i = 0; i < 10; i++) begin
      send_sample(8'($urandom_range(120, 130)), SPACING);
    end
    send_sample(8'd255, SPACING);
    settle(2'd1);

    // Back-to-back crossings while the sequencer holds
    base_threshold = 8'd100;
    hysteresis     = 4'd4;
    for (i = 0; i < 12; i++) begin
      send_sample((i % 2 == 0) ? 8'd0 : 8'd255, 1);
    end
    settle(2'd2);

    // Reset while the backlog is still draining, then run again
    pulse_reset();
    for (i = 0; i < 8; i++) begin
      send_sample(8'($urandom_range(90, 110)), SPACING);
    end
    settle(2'd1);

    assert_fails = i_brownout_monitor_top.i_reset_sequencer.i_seq_chk.fail_count +
                   i_brownout_monitor_top.i_event_fifo.i_fifo_chk.fail_count;
    $display("Errors: checker %0d, assertions %0d", i_checker.err_count, assert_fails);
    if (i_checker.err_count == 0 && assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Cycle counter guarding against a stuck run
  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: stimulus did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
hw/brownout_pkg.sv
hw/brownout_event_if.sv
hw/threshold_detector.sv
hw/event_fifo.sv
hw/reset_sequencer.sv
hw/brownout_monitor_top.sv
tb/brownout_monitor_checker.sv
tb/brownout_monitor_chk.sv
tb/brownout_monitor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module brownout_monitor_tb -f src.f -o brownout_sim
./obj_dir/brownout_sim +verilator+error+limit+100 | tee sim.log

if grep -q "Test failures found" sim.log; then
  exit 1
fi
